/* compile.f */
design/i3c_pkg.sv
design/i3c_csr.sv
design/i3c_xfer_ctrl.sv
design/i3c_dat_ram.sv
design/i3c_bit_phy.sv
design/i3c_wrapper.sv
verif/i3c_target_model.sv
verif/tb_i3c_wrapper.sv

/* Makefile */
TOP := tb_i3c_wrapper

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_i3c_wrapper.sv */
// Directed testbench; reads DAT contents through the hierarchical path to the RAM array
`timescale 1ns/1ps

module tb_i3c_wrapper;
  import i3c_pkg::*;

  localparam int DONE_TIMEOUT = 1000;
  localparam int STOP_TIMEOUT = 200;
  localparam int QUIET_CYCLES = 200;

  logic        clk;
  logic        arst_n;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic        reg_we;
  logic        reg_re;
  logic [31:0] reg_rdata;
  logic        scl;
  logic        sda_ctrl;
  logic        sda_bus;
  logic        sel_od_pp;
  logic        irq;
  logic [6:0]  own_addr;
  dat_entry_t  exp_dat [DAT_DEPTH];

  i3c_wrapper i3c_wrapper_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_we_i    (reg_we),
    .reg_re_i    (reg_re),
    .reg_rdata_o (reg_rdata),
    .scl_i       (scl),
    .sda_i       (sda_bus),
    .scl_o       (scl),
    .sda_o       (sda_ctrl),
    .sel_od_pp_o (sel_od_pp),
    .irq_o       (irq)
  );

  i3c_target_model target_model_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .scl_i       (scl),
    .sda_i       (sda_ctrl),
    .sel_od_pp_i (sel_od_pp),
    .own_addr_i  (own_addr),
    .sda_o       (sda_bus)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dat(input string name, input dat_entry_t got, input dat_entry_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%016h expected 0x%016h", name, got, exp);
      abort_run();
    end
  endtask

  // All bus tasks start and end on a falling edge
  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_we    = 1'b1;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
    reg_addr = addr;
    reg_re   = 1'b1;
    @(negedge clk);
    reg_re   = 1'b0;
    data     = reg_rdata;
  endtask

  function automatic logic [7:0] dat_addr(input logic [DAT_AW-1:0] idx, input logic hi);
    return REG_DAT_BASE + {1'b0, idx, hi, 2'b00};
  endfunction

  function automatic dat_entry_t peek_dat(input logic [DAT_AW-1:0] idx);
    return dat_entry_t'(i3c_wrapper_i.i3c_dat_ram_i.mem_q[idx]);
  endfunction

  task automatic write_dat(input logic [DAT_AW-1:0] idx, input dat_entry_t e);
    reg_write(dat_addr(idx, 1'b0), e[31:0]);
    reg_write(dat_addr(idx, 1'b1), e[63:32]);
  endtask

  task automatic clear_status();
    reg_write(REG_STATUS, 32'h6);
  endtask

  task automatic wait_done(output status_t st);
    logic [31:0] rd;
    int          n;
    n = 0;
    reg_read(REG_STATUS, rd);
    while (!rd[1] && n < DONE_TIMEOUT) begin
      reg_read(REG_STATUS, rd);
      n++;
    end
    if (!rd[1]) begin
      $display("Timeout waiting for STATUS.done");
      abort_run();
    end
    st = status_t'(rd[2:0]);
  endtask

  task automatic wait_stops(input int count);
    int n;
    n = 0;
    while (target_model_i.stop_cnt < count && n < STOP_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (target_model_i.stop_cnt < count) begin
      $display("Timeout waiting for STOP on the bus");
      abort_run();
    end
  endtask

  task automatic send_cmd(input cmd_desc_u c, output status_t st);
    clear_status();
    reg_write(REG_CMD, c);
    wait_done(st);
  endtask

  // Expects an ACKed open-drain address byte and an ACKed push-pull payload
  task automatic check_frame(input int rx_base, input int stop_base,
                             input logic [7:0] addr_b, input logic [7:0] data_b);
    wait_stops(stop_base + 1);
    check_count("rx_cnt", target_model_i.rx_cnt, rx_base + 2);
    check_byte("addr byte", target_model_i.rx_byte[6'(rx_base)], addr_b);
    check_bit("addr ack", target_model_i.rx_ack[6'(rx_base)], 1'b1);
    check_bit("addr sel_od_pp_o", target_model_i.rx_pp[6'(rx_base)], 1'b0);
    check_byte("data byte", target_model_i.rx_byte[6'(rx_base + 1)], data_b);
    check_bit("data ack", target_model_i.rx_ack[6'(rx_base + 1)], 1'b1);
    check_bit("data sel_od_pp_o", target_model_i.rx_pp[6'(rx_base + 1)], 1'b1);
  endtask

  task automatic test_reset_state();
    logic [31:0] rd;
    check_bit("scl_o", scl, 1'b1);
    check_bit("sda_o", sda_ctrl, 1'b1);
    check_bit("sel_od_pp_o", sel_od_pp, 1'b0);
    check_bit("irq_o", irq, 1'b0);
    reg_read(REG_STATUS, rd);
    check_status("STATUS", status_t'(rd[2:0]), '0);
    check_count("STATUS upper", int'(rd[31:3]), 0);
  endtask

  task automatic test_dat_window();
    logic [31:0] word;
    for (int i = 0; i < DAT_DEPTH; i++) begin
      exp_dat[DAT_AW'(i)] = dat_entry_t'({$urandom, $urandom});
      write_dat(DAT_AW'(i), exp_dat[DAT_AW'(i)]);
    end
    for (int i = 0; i < DAT_DEPTH; i++) begin
      check_dat($sformatf("DAT[%0d]", i), peek_dat(DAT_AW'(i)), exp_dat[DAT_AW'(i)]);
    end
    // Single-half writes leave the other half alone
    word = $urandom;
    reg_write(dat_addr(4'd5, 1'b0), word);
    exp_dat[5][31:0] = word;
    word = $urandom;
    reg_write(dat_addr(4'd9, 1'b1), word);
    exp_dat[9][63:32] = word;
    for (int i = 0; i < DAT_DEPTH; i++) begin
      check_dat($sformatf("DAT[%0d]", i), peek_dat(DAT_AW'(i)), exp_dat[DAT_AW'(i)]);
    end
  endtask

  task automatic test_static_write();
    dat_entry_t e;
    cmd_desc_u  c;
    status_t    st;
    status_t    exp_st;
    logic [7:0] data;
    int         rx_base;
    int         stop_base;
    e             = '0;
    e.static_addr = 7'h2A;
    e.dyn_addr    = 7'h11;
    data          = 8'($urandom);
    own_addr      = 7'h2A;
    write_dat(4'd2, e);
    reg_write(REG_IRQ_EN, 32'h1);
    rx_base   = target_model_i.rx_cnt;
    stop_base = target_model_i.stop_cnt;
    c                 = '0;
    c.regular.attr    = CMD_ATTR_REGULAR;
    c.regular.dat_idx = 4'd2;
    c.regular.data    = data;
    send_cmd(c, st);
    exp_st      = '0;
    exp_st.done = 1'b1;
    check_status("STATUS", st, exp_st);
    check_bit("irq_o", irq, 1'b1);
    check_frame(rx_base, stop_base, {7'h2A, 1'b0}, data);
    reg_write(REG_IRQ_EN, 32'h0);
    check_bit("irq_o", irq, 1'b0);
  endtask

  task automatic test_dyn_select();
    dat_entry_t e;
    cmd_desc_u  c;
    status_t    st;
    status_t    exp_st;
    logic [7:0] data;
    int         rx_base;
    int         stop_base;
    // Static address is a decoy that the target does not own
    e             = '0;
    e.static_addr = 7'h2A;
    e.dyn_addr    = 7'h33;
    e.use_dyn     = 1'b1;
    data          = 8'($urandom);
    own_addr      = 7'h33;
    write_dat(4'd7, e);
    rx_base   = target_model_i.rx_cnt;
    stop_base = target_model_i.stop_cnt;
    c                 = '0;
    c.regular.attr    = CMD_ATTR_REGULAR;
    c.regular.dat_idx = 4'd7;
    c.regular.data    = data;
    send_cmd(c, st);
    exp_st      = '0;
    exp_st.done = 1'b1;
    check_status("STATUS", st, exp_st);
    check_bit("irq_o", irq, 1'b0);
    check_frame(rx_base, stop_base, {7'h33, 1'b0}, data);
  endtask

  task automatic test_ccc_broadcast();
    cmd_desc_u  c;
    status_t    st;
    status_t    exp_st;
    logic [7:0] code;
    int         rx_base;
    int         stop_base;
    code      = 8'($urandom);
    rx_base   = target_model_i.rx_cnt;
    stop_base = target_model_i.stop_cnt;
    c              = '0;
    c.ccc.attr     = CMD_ATTR_CCC;
    c.ccc.ccc_code = code;
    send_cmd(c, st);
    exp_st      = '0;
    exp_st.done = 1'b1;
    check_status("STATUS", st, exp_st);
    check_frame(rx_base, stop_base, {7'h7E, 1'b0}, code);
  endtask

  task automatic test_nack_and_drop();
    dat_entry_t  e;
    cmd_desc_u   c;
    cmd_desc_u   c_busy;
    status_t     st;
    status_t     exp_st;
    logic [31:0] rd;
    logic [7:0]  data;
    int          rx_base;
    int          stop_base;
    int          start_base;
    e             = '0;
    e.static_addr = 7'h5A;
    own_addr      = 7'h33;
    write_dat(4'd4, e);
    rx_base   = target_model_i.rx_cnt;
    stop_base = target_model_i.stop_cnt;
    c                 = '0;
    c.regular.dat_idx = 4'd4;
    c.regular.data    = 8'($urandom);
    send_cmd(c, st);
    exp_st      = '0;
    exp_st.done = 1'b1;
    exp_st.nack = 1'b1;
    check_status("STATUS", st, exp_st);
    wait_stops(stop_base + 1);
    check_count("rx_cnt", target_model_i.rx_cnt, rx_base + 1);
    check_byte("addr byte", target_model_i.rx_byte[6'(rx_base)], {7'h5A, 1'b0});
    check_bit("addr ack", target_model_i.rx_ack[6'(rx_base)], 1'b0);
    reg_read(REG_STATUS, rd);
    check_status("STATUS", status_t'(rd[2:0]), exp_st);
    clear_status();
    reg_read(REG_STATUS, rd);
    check_status("STATUS", status_t'(rd[2:0]), '0);

    // Entry 7 is owned by the target, so the payload shows which command ran
    data       = 8'($urandom);
    rx_base    = target_model_i.rx_cnt;
    stop_base  = target_model_i.stop_cnt;
    start_base = target_model_i.start_cnt;
    c.regular.dat_idx   = 4'd7;
    c.regular.data      = data;
    c_busy              = c;
    c_busy.regular.data = ~data;
    reg_write(REG_CMD, c);
    reg_write(REG_CMD, c_busy);
    reg_read(REG_STATUS, rd);
    exp_st      = '0;
    exp_st.busy = 1'b1;
    check_status("STATUS", status_t'(rd[2:0]), exp_st);
    wait_done(st);
    exp_st      = '0;
    exp_st.done = 1'b1;
    check_status("STATUS", st, exp_st);
    check_frame(rx_base, stop_base, {7'h33, 1'b0}, data);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      check_count("start_cnt", target_model_i.start_cnt, start_base + 1);
    end
  endtask

  initial begin
    void'($urandom(62955));
    arst_n    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    own_addr  = 7'h2A;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_dat_window();
    test_static_write();
    test_dyn_select();
    test_ccc_broadcast();
    test_nack_and_drop();

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* verif/i3c_target_model.sv */
// Behavioral I3C target on a digital bus; ACKs its own address and 7'h7E, logs at most 64 bytes
`timescale 1ns/1ps

module i3c_target_model (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  input  logic       sel_od_pp_i,
  input  logic [6:0] own_addr_i,
  output logic       sda_o
);
  import i3c_pkg::*;

  logic       pull_q;
  logic       scl_q;
  logic       sda_q;
  logic [3:0] bit_cnt;
  logic [7:0] shift_q;
  logic       addr_phase;
  logic       selected;
  logic       pp_seen;
  logic       scl_rise;
  logic       scl_fall;
  logic       addr_match;
  logic [7:0] rx_byte [64];
  logic       rx_ack  [64];
  logic       rx_pp   [64];
  int         rx_cnt;
  int         start_cnt;
  int         stop_cnt;

  // Wired AND while open-drain, the controller owns the line in push-pull
  assign sda_o      = sel_od_pp_i ? sda_i : (sda_i & ~pull_q);
  assign scl_rise   = !scl_q && scl_i;
  assign scl_fall   = scl_q && !scl_i;
  assign addr_match = !shift_q[0] &&
                      (shift_q[7:1] == own_addr_i || shift_q[7:1] == CCC_BCAST_ADDR);

  // Bus sampled mid-cycle, away from the controller's clock edge
  always_ff @(negedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pull_q     <= 1'b0;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      bit_cnt    <= '0;
      shift_q    <= '0;
      addr_phase <= 1'b0;
      selected   <= 1'b0;
      pp_seen    <= 1'b0;
      rx_cnt     <= 0;
      start_cnt  <= 0;
      stop_cnt   <= 0;
    end else begin
      scl_q <= scl_i;
      sda_q <= sda_o;
      if (scl_q && scl_i && sda_q && !sda_o) begin
        // START
        start_cnt  <= start_cnt + 1;
        bit_cnt    <= '0;
        addr_phase <= 1'b1;
        selected   <= 1'b0;
        pp_seen    <= 1'b0;
      end else if (scl_q && scl_i && !sda_q && sda_o) begin
        // STOP
        stop_cnt <= stop_cnt + 1;
        bit_cnt  <= '0;
        selected <= 1'b0;
        pull_q   <= 1'b0;
      end else if (scl_rise) begin
        if (bit_cnt < 4'd8) begin
          shift_q <= {shift_q[6:0], sda_o};
          pp_seen <= pp_seen | sel_od_pp_i;
          bit_cnt <= bit_cnt + 4'd1;
        end else if (bit_cnt == 4'd8) begin
          // Ninth bit is the ACK slot
          rx_byte[6'(rx_cnt)] <= shift_q;
          rx_ack[6'(rx_cnt)]  <= !sda_o;
          rx_pp[6'(rx_cnt)]   <= pp_seen;
          rx_cnt              <= rx_cnt + 1;
          bit_cnt             <= 4'd9;
        end
      end else if (scl_fall) begin
        if (bit_cnt == 4'd8) begin
          if (addr_phase) begin
            selected <= addr_match;
            pull_q   <= addr_match;
          end else begin
            pull_q <= selected;
          end
        end else if (bit_cnt == 4'd9) begin
          pull_q     <= 1'b0;
          bit_cnt    <= '0;
          addr_phase <= 1'b0;
          pp_seen    <= 1'b0;
        end
      end
    end
  end

endmodule

/* design/i3c_wrapper.sv */
// Controller top with digital bus pins only; scl_i is a monitor input and not used by the phy
`timescale 1ns/1ps

module i3c_wrapper (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic [7:0]  reg_addr_i,
  input  logic [31:0] reg_wdata_i,
  input  logic        reg_we_i,
  input  logic        reg_re_i,
  output logic [31:0] reg_rdata_o,
  input  logic        scl_i,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        sel_od_pp_o,
  output logic        irq_o
);
  import i3c_pkg::*;

  cmd_desc_u    cmd;
  logic         cmd_valid;
  status_t      status;
  logic         xfer_done;
  logic         nack;
  dat_mem_req_t csr_dat_req;
  dat_mem_req_t ctrl_dat_req;
  dat_mem_req_t ram_req;
  dat_mem_rsp_t ram_rsp;
  logic         csr_dat_gnt;
  phy_req_t     phy_req;
  logic         byte_done;
  logic         ack_ok;

  // DAT port mux, the controller fetch has priority
  assign ram_req     = ctrl_dat_req.req ? ctrl_dat_req : csr_dat_req;
  assign csr_dat_gnt = csr_dat_req.req && !ctrl_dat_req.req;

  i3c_csr i3c_csr_i (
    .clk_i,
    .arst_n_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_we_i,
    .reg_re_i,
    .reg_rdata_o,
    .irq_o,
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .dat_req_o   (csr_dat_req),
    .dat_gnt_i   (csr_dat_gnt),
    .status_i    (status),
    .xfer_done_i (xfer_done),
    .nack_i      (nack)
  );

  i3c_xfer_ctrl i3c_xfer_ctrl_i (
    .clk_i,
    .arst_n_i,
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .dat_req_o   (ctrl_dat_req),
    .dat_rsp_i   (ram_rsp),
    .phy_req_o   (phy_req),
    .byte_done_i (byte_done),
    .ack_ok_i    (ack_ok),
    .status_o    (status),
    .xfer_done_o (xfer_done),
    .nack_o      (nack)
  );

  i3c_dat_ram i3c_dat_ram_i (
    .clk_i,
    .arst_n_i,
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  i3c_bit_phy i3c_bit_phy_i (
    .clk_i,
    .arst_n_i,
    .req_i       (phy_req),
    .sda_i,
    .scl_o,
    .sda_o,
    .sel_od_pp_o,
    .byte_done_o (byte_done),
    .ack_ok_o    (ack_ok)
  );

endmodule

/* design/i3c_bit_phy.sv */
// SCL/SDA bit engine; first must be set only from an idle bus, no repeated START, no clock stretch
`timescale 1ns/1ps

module i3c_bit_phy (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  i3c_pkg::phy_req_t req_i,
  input  logic              sda_i,
  output logic              scl_o,
  output logic              sda_o,
  output logic              sel_od_pp_o,
  output logic              byte_done_o,
  output logic              ack_ok_o
);
  import i3c_pkg::*;

  phy_state_e           state_q;
  logic [SCL_CNT_W-1:0] cnt_q;
  logic                 tick;
  logic                 half_q;
  logic [3:0]           bit_q;
  logic [7:0]           shift_q;
  logic                 od_q;
  logic                 last_q;
  logic                 ack_q;
  logic                 done_q;
  logic                 parked;
  logic                 sda_d;
  logic                 sel_d;
  logic                 sda_q;
  logic                 sel_q;

  assign tick   = cnt_q == SCL_CNT_W'(SCL_HALF_CYCLES - 1);
  assign parked = (state_q == PHY_IDLE) || (state_q == PHY_HOLD);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PHY_IDLE;
      cnt_q   <= '0;
      half_q  <= 1'b0;
      bit_q   <= '0;
      ack_q   <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      cnt_q  <= (parked || tick) ? '0 : cnt_q + 1'b1;
      case (state_q)
        PHY_IDLE, PHY_HOLD: begin
          if (req_i.start) begin
            bit_q   <= '0;
            half_q  <= 1'b0;
            state_q <= req_i.first ? PHY_START : PHY_BIT;
          end
        end
        PHY_START: if (tick) state_q <= PHY_BIT;
        PHY_BIT: begin
          if (tick) begin
            half_q <= ~half_q;
            if (half_q && bit_q == BIT_ACK) begin
              // Sample at the end of SCL high
              ack_q <= ~sda_i;
              if (last_q || sda_i) begin
                state_q <= PHY_STOP_LO;
              end else begin
                state_q <= PHY_HOLD;
                done_q  <= 1'b1;
              end
            end else if (half_q) begin
              bit_q <= bit_q + 1'b1;
            end
          end
        end
        PHY_STOP_LO: if (tick) state_q <= PHY_STOP_HI;
        PHY_STOP_HI: begin
          if (tick) begin
            state_q <= PHY_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= PHY_IDLE;
      endcase
    end
  end

  // Byte shifter and frame flags, MSB first
  always_ff @(posedge clk_i) begin
    if (parked && req_i.start) begin
      shift_q <= req_i.tx_byte;
      od_q    <= req_i.od;
      last_q  <= req_i.last;
    end else if (state_q == PHY_BIT && tick && half_q) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  always_comb begin
    scl_o = 1'b1;
    sda_d = 1'b1;
    sel_d = 1'b0;
    case (state_q)
      PHY_START: sda_d = 1'b0;
      PHY_BIT: begin
        scl_o = half_q;
        if (bit_q != BIT_ACK) begin
          sda_d = shift_q[7];
          sel_d = ~od_q;
        end
      end
      PHY_STOP_LO: begin
        scl_o = 1'b0;
        sda_d = 1'b0;
      end
      PHY_STOP_HI: sda_d = 1'b0;
      PHY_HOLD:    scl_o = 1'b0;
      default: ;
    endcase
  end

  // SDA lags SCL by one cycle so START/STOP edges land with SCL high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sda_q <= 1'b1;
      sel_q <= 1'b0;
    end else begin
      sda_q <= sda_d;
      sel_q <= sel_d;
    end
  end

  assign sda_o       = sda_q;
  assign sel_od_pp_o = sel_q;
  assign byte_done_o = done_q;
  assign ack_ok_o    = ack_q;

  // Target drives ACK while SCL is high, so no push-pull then
  a_ack_open_drain : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q == PHY_BIT && bit_q == BIT_ACK && half_q |-> !sel_od_pp_o);

endmodule

/* design/i3c_dat_ram.sv */
// Single-port DAT memory, 32-bit write granularity, read data one cycle after the request
`timescale 1ns/1ps

module i3c_dat_ram (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  i3c_pkg::dat_mem_req_t req_i,
  output i3c_pkg::dat_mem_rsp_t rsp_o
);
  import i3c_pkg::*;

  logic [63:0] mem_q [DAT_DEPTH];
  logic [63:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.write) begin
      for (int h = 0; h < 2; h++) begin
        if (req_i.wmask[h]) begin
          mem_q[req_i.addr][h*32 +: 32] <= req_i.wdata[h*32 +: 32];
        end
      end
    end
  end

  // Read port register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (req_i.req && !req_i.write) begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  assign rsp_o.rdata = rdata_q;

  a_addr_range : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.req |-> int'(req_i.addr) < DAT_DEPTH);

endmodule

/* design/i3c_xfer_ctrl.sv */
// Frame sequencer for private writes and broadcast CCCs; one command in flight, no reads
`timescale 1ns/1ps

module i3c_xfer_ctrl (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cmd_valid_i,
  input  i3c_pkg::cmd_desc_u    cmd_i,
  output i3c_pkg::dat_mem_req_t dat_req_o,
  input  i3c_pkg::dat_mem_rsp_t dat_rsp_i,
  output i3c_pkg::phy_req_t     phy_req_o,
  input  logic                  byte_done_i,
  input  logic                  ack_ok_i,
  output i3c_pkg::status_t      status_o,
  output logic                  xfer_done_o,
  output logic                  nack_o
);
  import i3c_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  cmd_desc_u   cmd_q;
  dat_entry_t  entry;
  logic [6:0]  tgt_addr;
  logic [7:0]  payload;
  logic        is_ccc;
  logic        done_q;
  logic        nack_q;

  assign is_ccc = cmd_q.regular.attr == CMD_ATTR_CCC;
  assign entry  = dat_entry_t'(dat_rsp_i.rdata);

  // DAT read data is valid in S_ADDR, one cycle after the fetch
  always_comb begin
    if (is_ccc) begin
      tgt_addr = CCC_BCAST_ADDR;
    end else if (entry.use_dyn) begin
      tgt_addr = entry.dyn_addr;
    end else begin
      tgt_addr = entry.static_addr;
    end
  end

  assign payload = is_ccc ? cmd_q.ccc.ccc_code : cmd_q.regular.data;

  always_comb begin
    state_d     = state_q;
    dat_req_o   = '0;
    phy_req_o   = '0;
    xfer_done_o = 1'b0;
    nack_o      = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (cmd_valid_i) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        // CCCs skip the fetch but keep the same latency
        dat_req_o.req  = !is_ccc;
        dat_req_o.addr = cmd_q.regular.dat_idx;
        state_d        = S_ADDR;
      end
      S_ADDR: begin
        phy_req_o.start   = 1'b1;
        phy_req_o.tx_byte = {tgt_addr, 1'b0};
        phy_req_o.first   = 1'b1;
        phy_req_o.od      = 1'b1;
        state_d           = S_ADDR_WAIT;
      end
      S_ADDR_WAIT: begin
        if (byte_done_i) begin
          if (ack_ok_i) begin
            state_d = S_DATA;
          end else begin
            // Phy has already sent STOP
            xfer_done_o = 1'b1;
            nack_o      = 1'b1;
            state_d     = S_IDLE;
          end
        end
      end
      S_DATA: begin
        phy_req_o.start   = 1'b1;
        phy_req_o.tx_byte = payload;
        phy_req_o.last    = 1'b1;
        state_d           = S_DATA_WAIT;
      end
      S_DATA_WAIT: begin
        if (byte_done_i) begin
          xfer_done_o = 1'b1;
          nack_o      = !ack_ok_i;
          state_d     = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      done_q  <= 1'b0;
      nack_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (cmd_valid_i) begin
        done_q <= 1'b0;
        nack_q <= 1'b0;
      end else if (xfer_done_o) begin
        done_q <= 1'b1;
        nack_q <= nack_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  // Outcome of the last frame, cleared at launch
  assign status_o.busy = state_q != S_IDLE;
  assign status_o.done = done_q;
  assign status_o.nack = nack_q;

  // The CSR busy drop must keep launches out of a running frame
  a_no_launch_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> state_q == S_IDLE);

endmodule

/* design/i3c_csr.sv */
// Register front end; DAT window is write-only, CMD writes while busy are silently dropped
`timescale 1ns/1ps

module i3c_csr (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [7:0]            reg_addr_i,
  input  logic [31:0]           reg_wdata_i,
  input  logic                  reg_we_i,
  input  logic                  reg_re_i,
  output logic [31:0]           reg_rdata_o,
  output logic                  irq_o,
  output logic                  cmd_valid_o,
  output i3c_pkg::cmd_desc_u    cmd_o,
  output i3c_pkg::dat_mem_req_t dat_req_o,
  input  logic                  dat_gnt_i,
  input  i3c_pkg::status_t      status_i,
  input  logic                  xfer_done_i,
  input  logic                  nack_i
);
  import i3c_pkg::*;

  dat_mem_req_t wr_req;
  dat_mem_req_t pend_q;
  status_t      st_rd;
  status_t      st_clr;
  logic         done_q;
  logic         nack_q;
  logic         irq_en_q;

  // Launch straight from the strobe, only when the controller is idle
  assign cmd_valid_o = reg_we_i && (reg_addr_i == REG_CMD) && !status_i.busy;
  assign cmd_o       = cmd_desc_u'(reg_wdata_i);

  // DAT window, address bit 2 picks the 32-bit half
  always_comb begin
    wr_req       = '0;
    wr_req.req   = reg_we_i && (reg_addr_i >= REG_DAT_BASE);
    wr_req.write = 1'b1;
    wr_req.addr  = reg_addr_i[DAT_AW+2:3];
    wr_req.wdata = {2{reg_wdata_i}};
    wr_req.wmask = reg_addr_i[2] ? 2'b10 : 2'b01;
  end

  // A write that loses to the DAT fetch goes out on the next cycle
  assign dat_req_o = pend_q.req ? pend_q : wr_req;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= '0;
    end else if (pend_q.req) begin
      if (dat_gnt_i) begin
        pend_q <= wr_req;
      end
    end else if (wr_req.req && !dat_gnt_i) begin
      pend_q <= wr_req;
    end
  end

  assign st_clr = status_t'(reg_wdata_i[2:0]);

  // Sticky flags, write 1 to clear; a new completion wins
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q   <= 1'b0;
      nack_q   <= 1'b0;
      irq_en_q <= 1'b0;
    end else begin
      if (xfer_done_i) begin
        done_q <= 1'b1;
        nack_q <= nack_i;
      end else if (reg_we_i && reg_addr_i == REG_STATUS) begin
        done_q <= done_q & ~st_clr.done;
        nack_q <= nack_q & ~st_clr.nack;
      end
      if (reg_we_i && reg_addr_i == REG_IRQ_EN) begin
        irq_en_q <= reg_wdata_i[0];
      end
    end
  end

  assign irq_o = done_q & irq_en_q;

  always_comb begin
    st_rd      = status_i;
    st_rd.done = done_q;
    st_rd.nack = nack_q;
  end

  always_ff @(posedge clk_i) begin
    if (reg_re_i) begin
      case (reg_addr_i)
        REG_STATUS: reg_rdata_o <= {29'b0, st_rd};
        REG_IRQ_EN: reg_rdata_o <= {31'b0, irq_en_q};
        default:    reg_rdata_o <= '0;
      endcase
    end
  end

  a_dat_wmask_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dat_req_o.req && dat_req_o.write |-> $onehot(dat_req_o.wmask));

endmodule

/* design/i3c_pkg.sv */
// Shared types for the I3C controller; DAT depth and SCL divider are fixed here, not per instance
package i3c_pkg;

  // DAT geometry
  localparam int DAT_DEPTH = 16;
  localparam int DAT_AW    = 4;

  // Bus timing, in clk_i cycles per SCL half period
  localparam int SCL_HALF_CYCLES = 4;
  localparam int SCL_CNT_W       = $clog2(SCL_HALF_CYCLES);

  localparam logic [6:0] CCC_BCAST_ADDR = 7'h7E;

  // Bit index of the ACK slot after eight data bits
  localparam logic [3:0] BIT_ACK = 4'd8;

  // Register map, byte offsets
  localparam logic [7:0] REG_CMD      = 8'h00;
  localparam logic [7:0] REG_STATUS   = 8'h04;
  localparam logic [7:0] REG_IRQ_EN   = 8'h08;
  localparam logic [7:0] REG_DAT_BASE = 8'h80;

  // Command attribute, top bit of the command word
  localparam logic CMD_ATTR_REGULAR = 1'b0;
  localparam logic CMD_ATTR_CCC     = 1'b1;

  typedef struct packed {
    logic [39:0] rsvd_hi;
    logic        use_dyn;
    logic [6:0]  dyn_addr;
    logic [8:0]  rsvd_lo;
    logic [6:0]  static_addr;
  } dat_entry_t;

  typedef struct packed {
    logic              attr;
    logic [14:0]       rsvd_hi;
    logic [7:0]        data;
    logic [3:0]        rsvd_lo;
    logic [DAT_AW-1:0] dat_idx;
  } regular_cmd_t;

  typedef struct packed {
    logic        attr;
    logic [22:0] rsvd;
    logic [7:0]  ccc_code;
  } ccc_cmd_t;

  // Same command word, view picked by attr
  typedef union packed {
    regular_cmd_t regular;
    ccc_cmd_t     ccc;
  } cmd_desc_u;

  typedef struct packed {
    logic              req;
    logic              write;
    logic [DAT_AW-1:0] addr;
    logic [63:0]       wdata;
    logic [1:0]        wmask;
  } dat_mem_req_t;

  typedef struct packed {
    logic [63:0] rdata;
  } dat_mem_rsp_t;

  // Bit 0 busy, bit 1 done, bit 2 nack
  typedef struct packed {
    logic nack;
    logic done;
    logic busy;
  } status_t;

  typedef struct packed {
    logic       start;
    logic [7:0] tx_byte;
    logic       first;
    logic       last;
    logic       od;
  } phy_req_t;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_ADDR, S_ADDR_WAIT, S_DATA, S_DATA_WAIT
  } ctrl_state_e;

  typedef enum logic [2:0] {
    PHY_IDLE, PHY_START, PHY_BIT, PHY_STOP_LO, PHY_STOP_HI, PHY_HOLD
  } phy_state_e;

endpackage
